// ==== common/f2c_cfg.svh ====
`ifndef F2C_CFG_SVH
`define F2C_CFG_SVH

// Width of an index into a host ring
`define F2C_RB_AWIDTH 10

// Width of one packet flit
`define F2C_FLIT_BITS 64

// Width of a queue id
`define F2C_QID_BITS 8

// Longest burst on the write bus, in flits
`define F2C_MAX_BURST 8

// Address step between two ring slots
`define F2C_FLIT_BYTES 64

`endif

// ==== common/f2c_pkg.sv ====
`include "f2c_cfg.svh"

package f2c_pkg;

  // Zero bits that fill a descriptor up to one flit
  localparam int DSC_PAD_BITS = `F2C_FLIT_BITS - 1 - `F2C_RB_AWIDTH - `F2C_QID_BITS;

  typedef struct packed {
    logic [`F2C_FLIT_BITS-1:0] data;
    logic                      sop;
  } flit_t;

  // One host ring with its base address and the next free slot
  typedef struct packed {
    logic [63:0]               kmem_addr;
    logic [`F2C_RB_AWIDTH-1:0] tail;
  } queue_state_t;

  typedef struct packed {
    logic [15:0]              size;             // In flits
    logic                     needs_dsc;
    logic                     descriptor_only;
    logic                     drop_data;
    logic                     drop_meta;
    logic [`F2C_QID_BITS-1:0] pkt_queue_id;
    queue_state_t             pkt_q_state;
    queue_state_t             dsc_q_state;
  } pkt_meta_t;

  // Descriptor as the host sees it in exactly one flit
  typedef struct packed {
    logic                      signal;
    logic [`F2C_RB_AWIDTH-1:0] tail;
    logic [`F2C_QID_BITS-1:0]  queue_id;
    logic [DSC_PAD_BITS-1:0]   pad;
  } rx_dsc_t;

  typedef enum logic [1:0] {
    START_TRANSFER,
    COMPLETE_BURST,
    START_BURST,
    SEND_DESCRIPTOR
  } f2c_state_t;

  // Selects which pair of event counters a write goes to
  typedef enum logic {
    PKT_FLIT,
    DESCRIPTOR
  } wr_kind_t;

endpackage

// ==== common/dma_wr_if.sv ====
`timescale 1ns/1ns
`include "f2c_cfg.svh"

interface dma_wr_if;

  logic                      req;
  f2c_pkg::wr_kind_t         kind;
  logic                      drop;
  logic [63:0]               address;
  logic [`F2C_FLIT_BITS-1:0] data;
  logic [3:0]                burstcount;  // Zero on continuation beats
  logic                      hold;

  modport seq (
    output req, kind, drop, address, data, burstcount,
    input  hold
  );

  modport bus (
    input  req, kind, drop, address, data, burstcount,
    output hold
  );

endinterface

// ==== rtl/f2c_meta_stage.sv ====
`timescale 1ns/1ns

module f2c_meta_stage (
  input  logic                clk,
  input  logic                rst,
  input  var f2c_pkg::pkt_meta_t meta_data,
  input  logic                meta_valid,
  output logic                meta_ready,
  output f2c_pkg::pkt_meta_t  staged,
  output logic                staged_valid,
  output logic                dsc_only,
  input  logic                meta_take
);

  f2c_pkg::pkt_meta_t meta_r1;
  logic               valid_r1;
  logic               advance;
  logic               ready_en;

  // Shift when the sequencer consumes the head or the head is empty
  assign advance = meta_take | ~staged_valid;

  // Upstream is only accepted once the stage is out of reset
  assign meta_ready = advance & ready_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_en     <= 1'b0;
      valid_r1     <= 1'b0;
      staged_valid <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (advance) begin
        valid_r1     <= meta_valid & meta_ready;
        staged_valid <= valid_r1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      meta_r1 <= meta_data;
      staged  <= meta_r1;
    end
  end

  assign dsc_only = staged_valid & staged.descriptor_only;

endmodule

// ==== rtl/f2c_dma_sequencer.sv ====
`timescale 1ns/1ns
`include "f2c_cfg.svh"

module f2c_dma_sequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  var f2c_pkg::pkt_meta_t    staged,
  input  logic                      staged_valid,
  input  logic                      dsc_only,
  output logic                      meta_take,
  input  var f2c_pkg::flit_t        flit,
  input  logic                      pkt_valid,
  output logic                      pkt_ready,
  input  logic [`F2C_RB_AWIDTH-1:0] pkt_rb_size,
  input  logic [`F2C_RB_AWIDTH-1:0] pkt_rb_mask,
  dma_wr_if.seq                     wr
);

  f2c_pkg::f2c_state_t state;
  f2c_pkg::f2c_state_t nxt_beat;
  f2c_pkg::pkt_meta_t  cur;
  f2c_pkg::pkt_meta_t  src;
  f2c_pkg::pkt_meta_t  adv;
  f2c_pkg::rx_dsc_t    dsc;
  logic [3:0]          left;
  logic [3:0]          left_now;
  logic [3:0]          blen;
  logic                first;
  logic                can_beat;
  logic                beat;
  logic                dsc_send;

  // Burst length is capped by the bus, the packet and the end of the ring
  function automatic logic [3:0] plan_burst(
    input logic [15:0]               size,
    input logic [`F2C_RB_AWIDTH-1:0] tail,
    input logic [`F2C_RB_AWIDTH-1:0] rb_size
  );
    logic [15:0]               n;
    logic [`F2C_RB_AWIDTH-1:0] room;
    room = rb_size - tail;
    n = 16'(`F2C_MAX_BURST);
    if (size < n) begin
      n = size;
    end
    if (16'(room) < n) begin
      n = 16'(room);
    end
    return n[3:0];
  endfunction

  always_comb begin
    // A new packet is planned straight from the staged metadata
    src      = (state == f2c_pkg::START_TRANSFER) ? staged : cur;
    first    = (state != f2c_pkg::COMPLETE_BURST);
    blen     = plan_burst(src.size, src.pkt_q_state.tail, pkt_rb_size);
    left_now = first ? blen : left;

    adv                  = src;
    adv.size             = src.size - 16'd1;
    adv.pkt_q_state.tail = (src.pkt_q_state.tail + 1'b1) & pkt_rb_mask;

    dsc.signal   = 1'b1;
    dsc.tail     = cur.pkt_q_state.tail;
    dsc.queue_id = cur.pkt_queue_id;
    dsc.pad      = '0;

    can_beat  = pkt_valid & ~wr.hold;
    beat      = 1'b0;
    dsc_send  = 1'b0;
    meta_take = 1'b0;
    case (state)
      f2c_pkg::START_TRANSFER: begin
        if (dsc_only) begin
          meta_take = 1'b1;
        end else if (staged_valid && can_beat) begin
          beat      = 1'b1;
          meta_take = 1'b1;
        end
      end
      f2c_pkg::COMPLETE_BURST, f2c_pkg::START_BURST: begin
        beat = can_beat;
      end
      f2c_pkg::SEND_DESCRIPTOR: begin
        if (!wr.hold) begin
          dsc_send  = 1'b1;
          meta_take = dsc_only;
        end
      end
      default: begin
        beat = 1'b0;
      end
    endcase
    pkt_ready = beat;

    // Where to go after this beat
    if (left_now != 4'd1) begin
      nxt_beat = f2c_pkg::COMPLETE_BURST;
    end else if (adv.size != 16'd0) begin
      nxt_beat = f2c_pkg::START_BURST;
    end else if (src.needs_dsc) begin
      nxt_beat = f2c_pkg::SEND_DESCRIPTOR;
    end else begin
      nxt_beat = f2c_pkg::START_TRANSFER;
    end

    wr.req  = beat | dsc_send;
    wr.kind = dsc_send ? f2c_pkg::DESCRIPTOR : f2c_pkg::PKT_FLIT;
    wr.drop = dsc_send ? cur.drop_meta : src.drop_data;
    if (dsc_send) begin
      wr.address    = cur.dsc_q_state.kmem_addr
                    + 64'(`F2C_FLIT_BYTES) * 64'(cur.dsc_q_state.tail);
      wr.data       = dsc;
      wr.burstcount = 4'd1;
    end else begin
      wr.address    = src.pkt_q_state.kmem_addr
                    + 64'(`F2C_FLIT_BYTES) * 64'(src.pkt_q_state.tail);
      wr.data       = flit.data;
      wr.burstcount = first ? blen : 4'd0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= f2c_pkg::START_TRANSFER;
      left  <= 4'd0;
    end else if (beat) begin
      state <= nxt_beat;
      left  <= left_now - 4'd1;
    end else if (state == f2c_pkg::START_TRANSFER && dsc_only) begin
      state <= f2c_pkg::SEND_DESCRIPTOR;
    end else if (dsc_send) begin
      // Back to back descriptors skip the idle state
      state <= dsc_only ? f2c_pkg::SEND_DESCRIPTOR : f2c_pkg::START_TRANSFER;
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      cur <= adv;
    end else if (meta_take) begin
      cur <= staged;
    end
  end

  // Upstream must only hand over rings that were set up by the host
  a_queue_addr: assert property (@(posedge clk) disable iff (rst)
    meta_take |-> (staged.pkt_q_state.kmem_addr != 64'd0 &&
                   staged.dsc_q_state.kmem_addr != 64'd0));

  a_single_sop: assert property (@(posedge clk) disable iff (rst)
    (beat && state == f2c_pkg::START_TRANSFER && staged.size == 16'd1) |-> flit.sop);

  // A stalled transfer keeps its place in the burst and issues nothing new
  a_hold_freeze: assert property (@(posedge clk) disable iff (rst)
    (wr.hold && state != f2c_pkg::START_TRANSFER) |=> ($stable(state) && $stable(left)));

endmodule

// ==== rtl/f2c_bus_stage.sv ====
`timescale 1ns/1ns
`include "f2c_cfg.svh"

module f2c_bus_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      waitrequest,
  dma_wr_if.bus                     wr,
  output logic                      bus_write,
  output logic [63:0]               bus_address,
  output logic [`F2C_FLIT_BITS-1:0] bus_writedata,
  output logic [3:0]                bus_burstcount,
  output logic [31:0]               dma_pkt_flit_cnt,
  output logic [31:0]               dma_pkt_flit_drop_cnt,
  output logic [31:0]               dma_dsc_cnt,
  output logic [31:0]               dma_dsc_drop_cnt
);

  logic                      write_r1;
  logic [63:0]               address_r1;
  logic [`F2C_FLIT_BITS-1:0] data_r1;
  logic [3:0]                burst_r1;
  logic                      take;

  // The sequencer and both register stages stall on the same waitrequest
  assign wr.hold = waitrequest;
  assign take    = wr.req & ~wr.hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      write_r1  <= 1'b0;
      bus_write <= 1'b0;
    end else if (!waitrequest) begin
      write_r1  <= take & ~wr.drop;
      bus_write <= write_r1;
    end
  end

  always_ff @(posedge clk) begin
    if (!waitrequest) begin
      address_r1     <= wr.address;
      data_r1        <= wr.data;
      burst_r1       <= wr.burstcount;
      bus_address    <= address_r1;
      bus_writedata  <= data_r1;
      bus_burstcount <= burst_r1;
    end
  end

  // Dropped items are counted when taken even though nothing reaches the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      dma_pkt_flit_cnt      <= 32'd0;
      dma_pkt_flit_drop_cnt <= 32'd0;
      dma_dsc_cnt           <= 32'd0;
      dma_dsc_drop_cnt      <= 32'd0;
    end else if (take) begin
      case ({wr.kind == f2c_pkg::DESCRIPTOR, wr.drop})
        2'b00:   dma_pkt_flit_cnt      <= dma_pkt_flit_cnt + 32'd1;
        2'b01:   dma_pkt_flit_drop_cnt <= dma_pkt_flit_drop_cnt + 32'd1;
        2'b10:   dma_dsc_cnt           <= dma_dsc_cnt + 32'd1;
        default: dma_dsc_drop_cnt      <= dma_dsc_drop_cnt + 32'd1;
      endcase
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (bus_write && waitrequest) |=>
      ($stable(bus_write) && $stable(bus_address) &&
       $stable(bus_writedata) && $stable(bus_burstcount)));

endmodule

// ==== rtl/f2c_dma_top.sv ====
`timescale 1ns/1ns
`include "f2c_cfg.svh"

module f2c_dma_top (
  input  logic                      clk,
  input  logic                      rst,
  input  var f2c_pkg::flit_t        flit,
  input  logic                      pkt_valid,
  output logic                      pkt_ready,
  input  var f2c_pkg::pkt_meta_t    meta_data,
  input  logic                      meta_valid,
  output logic                      meta_ready,
  input  logic [`F2C_RB_AWIDTH:0]   pkt_rb_size,
  input  logic                      waitrequest,
  output logic                      bus_write,
  output logic [63:0]               bus_address,
  output logic [`F2C_FLIT_BITS-1:0] bus_writedata,
  output logic [3:0]                bus_burstcount,
  output logic [31:0]               dma_pkt_flit_cnt,
  output logic [31:0]               dma_pkt_flit_drop_cnt,
  output logic [31:0]               dma_dsc_cnt,
  output logic [31:0]               dma_dsc_drop_cnt
);

  logic [`F2C_RB_AWIDTH-1:0] pkt_rb_size_r;
  logic [`F2C_RB_AWIDTH-1:0] pkt_rb_mask;
  f2c_pkg::pkt_meta_t        staged;
  logic                      staged_valid;
  logic                      dsc_only;
  logic                      meta_take;

  // Ring size is a power of two so the mask wraps the tail
  always_ff @(posedge clk) begin
    pkt_rb_size_r <= pkt_rb_size[`F2C_RB_AWIDTH-1:0];
    pkt_rb_mask   <= pkt_rb_size[`F2C_RB_AWIDTH-1:0] - 1'b1;
  end

  dma_wr_if wr_bus ();

  f2c_meta_stage u_meta_stage (
    .clk          (clk),
    .rst          (rst),
    .meta_data    (meta_data),
    .meta_valid   (meta_valid),
    .meta_ready   (meta_ready),
    .staged       (staged),
    .staged_valid (staged_valid),
    .dsc_only     (dsc_only),
    .meta_take    (meta_take)
  );

  f2c_dma_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .staged       (staged),
    .staged_valid (staged_valid),
    .dsc_only     (dsc_only),
    .meta_take    (meta_take),
    .flit         (flit),
    .pkt_valid    (pkt_valid),
    .pkt_ready    (pkt_ready),
    .pkt_rb_size  (pkt_rb_size_r),
    .pkt_rb_mask  (pkt_rb_mask),
    .wr           (wr_bus)
  );

  f2c_bus_stage u_bus_stage (
    .clk                   (clk),
    .rst                   (rst),
    .waitrequest           (waitrequest),
    .wr                    (wr_bus),
    .bus_write             (bus_write),
    .bus_address           (bus_address),
    .bus_writedata         (bus_writedata),
    .bus_burstcount        (bus_burstcount),
    .dma_pkt_flit_cnt      (dma_pkt_flit_cnt),
    .dma_pkt_flit_drop_cnt (dma_pkt_flit_drop_cnt),
    .dma_dsc_cnt           (dma_dsc_cnt),
    .dma_dsc_drop_cnt      (dma_dsc_drop_cnt)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
  end

  // 4 ns period
  always #2 clk = ~clk;

  initial begin
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== verif/tb_f2c_dma.sv ====
`timescale 1ns/1ns
`include "f2c_cfg.svh"

module tb_f2c_dma;

  localparam int RING = 16;
  localparam logic [63:0] PKT_BASE = 64'h0000_0001_0000_0000;
  localparam logic [63:0] DSC_BASE = 64'h0000_0002_0000_0000;

  typedef struct {
    logic [63:0]               addr;
    logic [`F2C_FLIT_BITS-1:0] data;
    logic [3:0]                burst;
  } beat_t;

  logic                      clk;
  logic                      rst;
  f2c_pkg::flit_t            flit;
  logic                      pkt_valid;
  logic                      pkt_ready;
  f2c_pkg::pkt_meta_t        meta_data;
  logic                      meta_valid;
  logic                      meta_ready;
  logic [`F2C_RB_AWIDTH:0]   pkt_rb_size;
  logic                      waitrequest;
  logic                      bus_write;
  logic [63:0]               bus_address;
  logic [`F2C_FLIT_BITS-1:0] bus_writedata;
  logic [3:0]                bus_burstcount;
  logic [31:0]               dma_pkt_flit_cnt;
  logic [31:0]               dma_pkt_flit_drop_cnt;
  logic [31:0]               dma_dsc_cnt;
  logic [31:0]               dma_dsc_drop_cnt;

  integer seed = 32'h2613;
  f2c_pkg::flit_t     flit_q[$];
  f2c_pkg::pkt_meta_t meta_q[$];
  beat_t              exp_q[$];
  int flit_idx = 0;
  int meta_idx = 0;
  int pkt_tail = 0;
  int dsc_tail = 0;
  int m_flit = 0;
  int m_flit_drop = 0;
  int m_dsc = 0;
  int m_dsc_drop = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int limit = 500;
  int cycles = 0;
  bit wr_rand_en = 0;

  tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

  f2c_dma_top uut (
    .clk(clk), .rst(rst),
    .flit(flit), .pkt_valid(pkt_valid), .pkt_ready(pkt_ready),
    .meta_data(meta_data), .meta_valid(meta_valid), .meta_ready(meta_ready),
    .pkt_rb_size(pkt_rb_size), .waitrequest(waitrequest),
    .bus_write(bus_write), .bus_address(bus_address),
    .bus_writedata(bus_writedata), .bus_burstcount(bus_burstcount),
    .dma_pkt_flit_cnt(dma_pkt_flit_cnt), .dma_pkt_flit_drop_cnt(dma_pkt_flit_drop_cnt),
    .dma_dsc_cnt(dma_dsc_cnt), .dma_dsc_drop_cnt(dma_dsc_drop_cnt)
  );

  task automatic check_addr(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [`F2C_FLIT_BITS-1:0] exp,
                            input logic [`F2C_FLIT_BITS-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_burst(input string name, input logic [3:0] exp, input logic [3:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  function automatic int pick_in_range(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Reference model queues the item for upstream and the beats it must produce
  task automatic add_item(input int size, input bit dsc_only, input bit needs,
                          input bit dd, input bit dm);
    f2c_pkg::pkt_meta_t m;
    f2c_pkg::flit_t     f;
    f2c_pkg::rx_dsc_t   d;
    beat_t              b;
    int                 rem;
    int                 blen;
    int                 k;
    bit                 first;
    m = '0;
    m.size = dsc_only ? 16'd0 : 16'(size);
    m.needs_dsc = needs | dsc_only;
    m.descriptor_only = dsc_only;
    m.drop_data = dd;
    m.drop_meta = dm;
    m.pkt_queue_id = $random(seed);
    m.pkt_q_state.kmem_addr = PKT_BASE;
    m.pkt_q_state.tail = pkt_tail;
    m.dsc_q_state.kmem_addr = DSC_BASE;
    m.dsc_q_state.tail = dsc_tail;
    meta_q.push_back(m);
    limit += 20 * (size + 1);
    rem = dsc_only ? 0 : size;
    first = 1'b1;
    while (rem > 0) begin
      // A burst stops at 8 flits, at the packet end or at the ring end
      blen = (rem > `F2C_MAX_BURST) ? `F2C_MAX_BURST : rem;
      if (blen > RING - pkt_tail) begin
        blen = RING - pkt_tail;
      end
      for (k = 0; k < blen; k++) begin
        f.data = {$random(seed), $random(seed)};
        f.sop = first;
        first = 1'b0;
        flit_q.push_back(f);
        if (dd) begin
          m_flit_drop++;
        end else begin
          b.addr = PKT_BASE + 64'(`F2C_FLIT_BYTES) * 64'(pkt_tail);
          b.data = f.data;
          b.burst = (k == 0) ? 4'(blen) : 4'd0;
          exp_q.push_back(b);
          m_flit++;
        end
        pkt_tail = (pkt_tail + 1) % RING;
        rem--;
      end
    end
    if (m.needs_dsc) begin
      d.signal = 1'b1;
      d.tail = pkt_tail;
      d.queue_id = m.pkt_queue_id;
      d.pad = '0;
      if (dm) begin
        m_dsc_drop++;
      end else begin
        b.addr = DSC_BASE + 64'(`F2C_FLIT_BYTES) * 64'(dsc_tail);
        b.data = d;
        b.burst = 4'd1;
        exp_q.push_back(b);
        m_dsc++;
      end
      dsc_tail = (dsc_tail + 1) % RING;
    end
  endtask

  task automatic add_random_item(input bit drops);
    bit dd;
    bit dm;
    dd = drops && (pick_in_range(0, 2) == 0);
    dm = drops && (pick_in_range(0, 2) == 0);
    if (pick_in_range(0, 9) < 2) begin
      add_item(0, 1'b1, 1'b1, 1'b0, dm);
    end else begin
      add_item(pick_in_range(1, 20), 1'b0, pick_in_range(0, 1), dd, dm);
    end
  endtask

  // Wait until every item is consumed, seen on the bus and taken by the DUT
  task automatic finish_test(input string name, input int errs_before);
    logic [31:0] total;
    total = m_flit + m_flit_drop + m_dsc + m_dsc_drop;
    while (!(flit_idx == flit_q.size() && meta_idx == meta_q.size() && exp_q.size() == 0 &&
             dma_pkt_flit_cnt + dma_pkt_flit_drop_cnt + dma_dsc_cnt + dma_dsc_drop_cnt
             == total)) begin
      @(negedge clk);
    end
    check_cnt("dma_pkt_flit_cnt", m_flit, dma_pkt_flit_cnt);
    check_cnt("dma_pkt_flit_drop_cnt", m_flit_drop, dma_pkt_flit_drop_cnt);
    check_cnt("dma_dsc_cnt", m_dsc, dma_dsc_cnt);
    check_cnt("dma_dsc_drop_cnt", m_dsc_drop, dma_dsc_drop_cnt);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    end
  endtask

  // Upstream streams and waitrequest driven from one process
  always @(posedge clk) begin
    if (rst) begin
      pkt_valid <= 1'b0;
      meta_valid <= 1'b0;
      waitrequest <= 1'b0;
    end else begin
      if (pkt_valid && pkt_ready) begin
        flit_idx = flit_idx + 1;
      end
      if (meta_valid && meta_ready) begin
        meta_idx = meta_idx + 1;
      end
      if (flit_idx < flit_q.size() && ($random(seed) & 3) != 0) begin
        pkt_valid <= 1'b1;
        flit <= flit_q[flit_idx];
      end else begin
        pkt_valid <= 1'b0;
      end
      if (meta_idx < meta_q.size() && ($random(seed) & 3) != 0) begin
        meta_valid <= 1'b1;
        meta_data <= meta_q[meta_idx];
      end else begin
        meta_valid <= 1'b0;
      end
      waitrequest <= wr_rand_en && ($unsigned($random(seed)) % 10 < 3);
    end
  end

  // Bus monitor
  logic        held = 1'b0;
  logic        prev_write;
  logic [63:0] prev_addr;
  logic [`F2C_FLIT_BITS-1:0] prev_data;
  logic [3:0]  prev_burst;
  beat_t       got;

  always @(posedge clk) begin
    if (!rst) begin
      if (held) begin
        check_burst("bus_write", 4'(prev_write), 4'(bus_write));
        check_addr("bus_address", prev_addr, bus_address);
        check_data("bus_writedata", prev_data, bus_writedata);
        check_burst("bus_burstcount", prev_burst, bus_burstcount);
      end
      if (bus_write && !waitrequest) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected bus write at %0t to address %h", $time, bus_address);
        end else begin
          got = exp_q.pop_front();
          check_addr("bus_address", got.addr, bus_address);
          check_data("bus_writedata", got.data, bus_writedata);
          check_burst("bus_burstcount", got.burst, bus_burstcount);
        end
      end
      held = bus_write && waitrequest;
      prev_write = bus_write;
      prev_addr = bus_address;
      prev_data = bus_writedata;
      prev_burst = bus_burstcount;
    end
  end

  // Watchdog whose limit grows as each test adds flits
  initial begin
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the DUT did not finish all items within %0d cycles", limit);
    $display("tests failed");
    $finish;
  end

  initial begin
    int e;
    int i;
    flit = '0;
    pkt_valid = 1'b0;
    meta_data = '0;
    meta_valid = 1'b0;
    pkt_rb_size = 11'(RING);
    waitrequest = 1'b0;
    wait (rst == 1'b0);
    @(negedge clk);

    e = errors;
    for (i = 0; i < 12; i++) begin
      add_item(1, 1'b0, 1'b1, 1'b0, 1'b0);
    end
    finish_test("single flit packets", e);

    e = errors;
    for (i = 0; i < 6; i++) begin
      add_item(pick_in_range(9, 20), 1'b0, pick_in_range(0, 1), 0, 0);
    end
    finish_test("multi burst packets", e);

    e = errors;
    for (i = 0; i < 4; i++) begin
      // Pad so the next packet starts two slots before the ring end
      if (((14 - pkt_tail) & 15) != 0) begin
        add_item((14 - pkt_tail) & 15, 1'b0, 1'b0, 1'b0, 1'b0);
      end
      add_item(pick_in_range(5, 12), 1'b0, 1'b1, 1'b0, 1'b0);
    end
    finish_test("ring wrap", e);

    e = errors;
    for (i = 0; i < 10; i++) begin
      if (i % 3 == 2) begin
        add_item(pick_in_range(1, 4), 1'b0, 1'b1, 1'b0, 1'b0);
      end else begin
        add_item(0, 1'b1, 1'b1, 1'b0, 1'b0);
      end
    end
    finish_test("descriptor only", e);

    e = errors;
    for (i = 0; i < 12; i++) begin
      add_random_item(1'b1);
    end
    finish_test("drop flags", e);

    e = errors;
    wr_rand_en = 1'b1;
    for (i = 0; i < 20; i++) begin
      add_random_item(1'b1);
    end
    finish_test("waitrequest back-pressure", e);
    wr_rand_en = 1'b0;

    // Catch any stray write after the last item
    repeat (10) @(negedge clk);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+common
common/f2c_pkg.sv
common/dma_wr_if.sv
rtl/f2c_meta_stage.sv
rtl/f2c_dma_sequencer.sv
rtl/f2c_bus_stage.sv
rtl/f2c_dma_top.sv
verif/tb_clk_gen.sv
verif/tb_f2c_dma.sv
